//--- dispatch_rs.f
+incdir+source
source/rs_pkg.sv
source/rs_entry.sv
source/rs_station.sv
source/issue_merge.sv
source/dispatch_rs.sv
tb/dispatch_rs_chk.sv
tb/dispatch_rs_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dispatch_rs testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert \
        -f dispatch_rs.f \
        --top-module dispatch_rs_tb \
        -Mdir "$OBJ" -o sim_dispatch_rs; then
    echo "build failed"
    exit 1
fi

if ! "./$OBJ/sim_dispatch_rs" > "$LOG" 2>&1; then
    echo "simulation returned a failing status"
fi

cat "$LOG"

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, see $LOG"
    exit 1
fi

//--- tb/dispatch_rs_tb.sv
`default_nettype none
`timescale 1ns/10ps

`include "rs_consts.svh"

module dispatch_rs_tb import rs_pkg::*;;

    localparam int NEVER    = 32'h3fffffff;  // tag not broadcast in this epoch
    localparam int FAIR_LEN = 40;
    localparam int CAP_LEN  = 60;
    localparam int BP_LEN   = 80;
    localparam int SQ_LEN   = 60;
    localparam int RAND_LEN = 4 * 150;       // four random rounds with drain
    localparam int LIMIT    = FAIR_LEN + CAP_LEN + BP_LEN + SQ_LEN + RAND_LEN + 200;

    logic clock = 1'b0;
    logic rst, squash, disp_valid, disp_rdy1, disp_rdy2, cdb_valid, issue_ready;
    inst_kind_t   disp_kind, issue_kind;
    tag_t         disp_dest, disp_tag1, disp_tag2, cdb_tag, issue_dest;
    value_t       disp_val1, disp_val2, cdb_value, issue_rs1, issue_rs2;
    alu_payload_t disp_alu, issue_alu;
    mem_payload_t disp_mem, issue_mem;
    logic         issue_valid, alu_full, mem_full;

    // staged inputs go out at the next rising edge
    logic st_rst, st_squash, st_disp, st_cdb, st_ready, st_rdy1, st_rdy2;
    inst_kind_t   st_kind;
    tag_t         st_dest, st_tag1, st_tag2, st_cdb_tag;
    value_t       st_val1, st_val2, st_cdb_val;
    alu_payload_t st_alu;
    mem_payload_t st_mem;

    // expected state per dest tag
    inst_kind_t   r_kind [32];
    alu_payload_t r_alu  [32];
    mem_payload_t r_mem  [32];
    logic         r_rdy1 [32], r_rdy2 [32], r_pend [32];
    tag_t         r_tag1 [32], r_tag2 [32];
    value_t       r_val1 [32], r_val2 [32];
    int           r_epoch[32];
    int           bcast_at[32];  // cycle the tag is on the bus
    int cyc = 0, epoch = 0, pending_count = 0, next_dest = 0;
    int fair_cnt = 0;
    logic fair_mode = 1'b0, ok;
    logic [31:0] seed = 32'h5b61da73;
    event checked;  // compare process done for this cycle

    dispatch_rs dut (.*);

    always #4 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // value the producer of a tag puts on the cdb
    function automatic value_t prod_value(input tag_t t, input int ep);
        return (32'(ep) * 32'h9e3779b9) ^ (32'(t) * 32'h85ebca6b) ^ 32'h5bd1e995;
    endfunction

    // operand an issued item must carry
    function automatic value_t expected_operand(input tag_t d, input logic second);
        if (!second) begin
            return r_rdy1[d] ? r_val1[d] : prod_value(r_tag1[d], r_epoch[d]);
        end
        return r_rdy2[d] ? r_val2[d] : prod_value(r_tag2[d], r_epoch[d]);
    endfunction

    // items of one kind held by the station or on their way in
    function automatic int station_count(input inst_kind_t k);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            if (r_pend[i] && r_kind[i] == k) begin
                n++;
            end
        end
        return n;
    endfunction

    // some pending item has every source on hand by this cycle
    function automatic logic any_ready();
        logic found;
        found = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (r_pend[i] && (r_rdy1[i] || bcast_at[r_tag1[i]] <= cyc) &&
                (r_rdy2[i] || bcast_at[r_tag2[i]] <= cyc)) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    // drive staged inputs at the rising edge and come back once the compare has run
    task automatic tick();
        @(posedge clock);
        rst         <= st_rst;
        squash      <= st_squash;
        issue_ready <= st_ready;
        disp_valid  <= st_disp;
        disp_kind   <= st_kind;
        disp_dest   <= st_dest;
        disp_tag1   <= st_tag1;
        disp_tag2   <= st_tag2;
        disp_rdy1   <= st_rdy1;
        disp_rdy2   <= st_rdy2;
        disp_val1   <= st_val1;
        disp_val2   <= st_val2;
        disp_alu    <= st_alu;
        disp_mem    <= st_mem;
        cdb_valid   <= st_cdb;
        cdb_tag     <= st_cdb_tag;
        cdb_value   <= st_cdb_val;
        st_disp   = 1'b0;  // strobes last one cycle
        st_cdb    = 1'b0;
        st_squash = 1'b0;
        @(checked);
    endtask

    task automatic clear_records();
        for (int i = 0; i < 32; i++) begin
            r_pend[i]   = 1'b0;
            bcast_at[i] = NEVER;
        end
        pending_count = 0;
        epoch++;  // fresh producer values
    endtask

    task automatic apply_reset();
        st_ready = 1'b0;
        st_rst   = 1'b1;
        tick();
        clear_records();
        repeat (2) tick();
        st_rst = 1'b0;
        tick();
    endtask

    task automatic squash_stations();
        st_ready = 1'b0;  // nothing consumed around the flush
        tick();
        st_squash = 1'b1;
        clear_records();
        tick();
        tick();  // entries flushed at this edge
        check_value(64'(issue_valid), 64'(0), "issue_valid after squash");
        check_value(64'(alu_full), 64'(0), "alu_full after squash");
        check_value(64'(mem_full), 64'(0), "mem_full after squash");
    endtask

    // source tags come from 16..31 and dest tags from 0..15
    task automatic pick_source(input int wait_pct, output tag_t t, output logic rdy,
                               output value_t v);
        logic [31:0] r;
        r = lcg_next();
        t = {1'b1, r[3:0]};
        if (bcast_at[t] != NEVER) begin
            rdy = 1'b1;
            v   = prod_value(t, epoch);
        end else begin
            rdy = !(r[31:8] % 100 < wait_pct);
            v   = lcg_next();  // dispatch value if ready, ignored while waiting
        end
    endtask

    task automatic stage_dispatch(input inst_kind_t k, input int wait_pct, output logic done);
        logic [31:0] r;
        tag_t d;
        done = 1'b0;
        if (station_count(k) >= `RS_DEPTH) begin
            return;
        end
        for (int i = 0; i < 16; i++) begin
            d = {1'b0, 4'(next_dest + i)};
            if (!r_pend[d]) begin
                break;
            end
        end
        next_dest = int'(d) + 1;
        r = lcg_next();
        pick_source(wait_pct, st_tag1, st_rdy1, st_val1);
        pick_source(wait_pct, st_tag2, st_rdy2, st_val2);
        st_disp        = 1'b1;
        st_kind        = k;
        st_dest        = d;
        st_alu.func    = alu_func_t'(4'(r[31:16] % 7));
        st_alu.imm     = lcg_next();
        st_alu.use_imm = r[0];
        st_mem.store   = r[1];
        st_mem.size    = r[3:2];
        st_mem.offset  = r[15:4];
        r_kind[d]  = k;
        r_alu[d]   = st_alu;
        r_mem[d]   = st_mem;
        r_tag1[d]  = st_tag1;
        r_tag2[d]  = st_tag2;
        r_rdy1[d]  = st_rdy1;
        r_rdy2[d]  = st_rdy2;
        r_val1[d]  = st_val1;
        r_val2[d]  = st_val2;
        r_epoch[d] = epoch;
        r_pend[d]  = 1'b1;
        pending_count++;
        done = 1'b1;
    endtask

    // broadcast one unsent tag and prefer the new item's source if asked
    task automatic stage_cdb(input logic prefer_disp);
        logic [31:0] r;
        tag_t t;
        logic found;
        r     = lcg_next();
        found = 1'b0;
        if (prefer_disp && r[8] && st_disp && !st_rdy1 && bcast_at[st_tag1] == NEVER) begin
            t     = st_tag1;
            found = 1'b1;
        end else begin
            for (int i = 0; i < 16; i++) begin
                t = {1'b1, 4'(int'(r[3:0]) + i)};
                if (bcast_at[t] == NEVER) begin
                    found = 1'b1;
                    break;
                end
            end
        end
        if (found) begin
            st_cdb      = 1'b1;
            st_cdb_tag  = t;
            st_cdb_val  = prod_value(t, epoch);
            bcast_at[t] = cyc + 1;
        end
    endtask

    task automatic drain();
        st_ready = 1'b1;
        while (pending_count > 0) begin
            stage_cdb(1'b0);
            tick();
        end
        tick();  // last item leaves at this edge
    endtask

    task automatic run_random(input int n, input logic hold_low);
        logic [31:0] r;
        logic done;
        repeat (n) begin
            r = lcg_next();
            st_ready = hold_low ? 1'b0 : (r[2:0] != 3'b0);
            if (r[15:8] < 8'd150) begin
                stage_dispatch(r[4] ? KIND_MEM : KIND_ALU, 50, done);
            end
            if (r[23:16] < 8'd90) begin
                stage_cdb(1'b1);
            end
            tick();
        end
    endtask

    // cycle counter and run limit
    always @(posedge clock) begin
        cyc = cyc + 1;
        if (cyc >= LIMIT) begin
            $display("the run timed out after %0d cycles", LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    // compare each accepted issue against its record
    always @(negedge clock) begin
        tag_t d;
        if (!rst && issue_valid && issue_ready) begin
            d = issue_dest;
            if (!r_pend[d]) begin
                report_error("an item issued that is not pending");
            end
            if ((!r_rdy1[d] && bcast_at[r_tag1[d]] > cyc) ||
                (!r_rdy2[d] && bcast_at[r_tag2[d]] > cyc)) begin
                report_error("an item issued before its source tag was broadcast");
            end
            check_value(64'(issue_kind), 64'(r_kind[d]), "issue_kind");
            if (r_kind[d] == KIND_ALU) begin
                check_value(64'(issue_alu), 64'(r_alu[d]), "alu payload");
            end else begin
                check_value(64'(issue_mem), 64'(r_mem[d]), "mem payload");
            end
            check_value(64'(issue_rs1), 64'(expected_operand(d, 1'b0)), "issue_rs1");
            check_value(64'(issue_rs2), 64'(expected_operand(d, 1'b1)), "issue_rs2");
            if (fair_mode) begin
                check_value(64'(issue_kind), 64'(fair_cnt % 2 == 0 ? KIND_ALU : KIND_MEM),
                            "alternating kind");
                fair_cnt++;
            end
            r_pend[d] = 1'b0;
            pending_count--;
        end
        -> checked;
    end

    initial begin
        rst         = 1'b1;
        squash      = 1'b0;
        disp_valid  = 1'b0;
        disp_kind   = KIND_ALU;
        disp_dest   = '0;
        disp_tag1   = '0;
        disp_tag2   = '0;
        disp_rdy1   = 1'b0;
        disp_rdy2   = 1'b0;
        disp_val1   = '0;
        disp_val2   = '0;
        disp_alu    = '0;
        disp_mem    = '0;
        cdb_valid   = 1'b0;
        cdb_tag     = '0;
        cdb_value   = '0;
        issue_ready = 1'b0;
        st_rst      = 1'b1;
        st_squash   = 1'b0;
        st_disp     = 1'b0;
        st_cdb      = 1'b0;
        st_ready    = 1'b0;
        st_kind     = KIND_ALU;
        st_dest     = '0;
        st_tag1     = '0;
        st_tag2     = '0;
        st_rdy1     = 1'b0;
        st_rdy2     = 1'b0;
        st_val1     = '0;
        st_val2     = '0;
        st_alu      = '0;
        st_mem      = '0;
        st_cdb_tag  = '0;
        st_cdb_val  = '0;
        apply_reset();

        // both banks loaded with ready items before the fairness release
        for (int i = 0; i < 2 * `RS_DEPTH; i++) begin
            stage_dispatch(i < `RS_DEPTH ? KIND_ALU : KIND_MEM, 0, ok);
            if (!ok) begin
                report_error("a station was full during the fairness fill");
            end
            tick();
        end
        fair_cnt  = 0;
        fair_mode = 1'b1;
        drain();
        fair_mode = 1'b0;
        check_value(64'(fair_cnt), 64'(2 * `RS_DEPTH), "issues in fairness phase");

        // capacity with every source waiting
        squash_stations();
        for (int i = 0; i < `RS_DEPTH; i++) begin
            stage_dispatch(KIND_ALU, 100, ok);
            tick();
        end
        tick();  // last dispatch lands at this edge
        check_value(64'(alu_full), 64'(1), "alu_full after filling");
        check_value(64'(mem_full), 64'(0), "mem_full while alu fills");
        drain();
        check_value(64'(alu_full), 64'(0), "alu_full after drain");

        // back-pressure stretch
        squash_stations();
        tick();
        run_random(5 + int'(lcg_next() % 16), 1'b1);
        tick();  // last dispatch and broadcast settle
        check_value(64'(issue_valid), 64'(any_ready()), "issue_valid under back-pressure");
        drain();

        // a full station of ready items is squashed before any issue
        squash_stations();
        for (int i = 0; i < `RS_DEPTH + 2; i++) begin
            if (i < `RS_DEPTH) begin
                stage_dispatch(KIND_ALU, 0, ok);
            end else begin
                stage_dispatch(KIND_MEM, 100, ok);
            end
            tick();
        end
        tick();
        check_value(64'(alu_full), 64'(1), "alu_full before squash");
        check_value(64'(issue_valid), 64'(1), "issue_valid before squash");
        squash_stations();
        for (int i = 0; i < 4; i++) begin
            stage_dispatch(i % 2 == 0 ? KIND_ALU : KIND_MEM, 50, ok);
            tick();
        end
        drain();

        // random rounds each start a fresh tag epoch
        repeat (4) begin
            squash_stations();
            run_random(100, 1'b0);
            drain();
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/dispatch_rs_chk.sv
`default_nettype none
`timescale 1ns/10ps

// protocol checks on the top level, bound into dispatch_rs
module dispatch_rs_chk import rs_pkg::*; (
    input wire logic       clock,
    input wire logic       rst,
    input wire logic       disp_valid,
    input wire inst_kind_t disp_kind,
    input wire logic       alu_full,
    input wire logic       mem_full,
    input wire logic       issue_ready,
    input wire logic       issue_valid,
    input wire logic       alu_grant,   // internal merger grants
    input wire logic       mem_grant
);

    // source must respect the full levels
    a_alu_not_full: assert property (@(posedge clock) disable iff (rst)
        (disp_valid && disp_kind == KIND_ALU) |-> !alu_full)
        else $error("dispatch strobe into a full alu station");

    a_mem_not_full: assert property (@(posedge clock) disable iff (rst)
        (disp_valid && disp_kind == KIND_MEM) |-> !mem_full)
        else $error("dispatch strobe into a full mem station");

    a_reset_idle: assert property (@(posedge clock) rst |=> !issue_valid)
        else $error("issue_valid high in the cycle after reset");

    a_one_grant: assert property (@(posedge clock) disable iff (rst)
        !(alu_grant && mem_grant))
        else $error("both stations granted in one cycle");

    // no grant under back-pressure
    a_hold: assert property (@(posedge clock) disable iff (rst)
        !issue_ready |-> !(alu_grant || mem_grant))
        else $error("grant given while issue_ready is low");

endmodule

bind dispatch_rs dispatch_rs_chk chk (
    .clock(clock), .rst(rst), .disp_valid(disp_valid), .disp_kind(disp_kind),
    .alu_full(alu_full), .mem_full(mem_full), .issue_ready(issue_ready),
    .issue_valid(issue_valid), .alu_grant(alu_grant), .mem_grant(mem_grant)
);

`default_nettype wire

//--- source/dispatch_rs.sv
`default_nettype none
`timescale 1ns/10ps

`include "rs_consts.svh"

// alu and mem reservation stations behind one dispatch port and one issue port
module dispatch_rs import rs_pkg::*; #(
    parameter int DEPTH = `RS_DEPTH  // entries per station, 2 or more
) (
    input  wire logic         clock,
    input  wire logic         rst,
    input  wire logic         squash,      // empties both stations
    input  wire logic         disp_valid,  // one cycle strobe
    input  wire inst_kind_t   disp_kind,
    input  wire tag_t         disp_dest,
    input  wire tag_t         disp_tag1,
    input  wire tag_t         disp_tag2,
    input  wire logic         disp_rdy1,
    input  wire logic         disp_rdy2,
    input  wire value_t       disp_val1,
    input  wire value_t       disp_val2,
    input  wire alu_payload_t disp_alu,
    input  wire mem_payload_t disp_mem,
    input  wire logic         cdb_valid,
    input  wire tag_t         cdb_tag,
    input  wire value_t       cdb_value,
    input  wire logic         issue_ready,
    output logic              issue_valid,
    output inst_kind_t        issue_kind,
    output tag_t              issue_dest,
    output value_t            issue_rs1,
    output value_t            issue_rs2,
    output alu_payload_t      issue_alu,
    output mem_payload_t      issue_mem,
    output logic              alu_full,
    output logic              mem_full
);

    logic         alu_alloc, mem_alloc;  // steered dispatch strobes
    logic         alu_req, mem_req;
    logic         alu_grant, mem_grant;
    tag_t         alu_dest, mem_dest;
    value_t       alu_op1, alu_op2, mem_op1, mem_op2;
    alu_payload_t alu_pl;
    mem_payload_t mem_pl;

    // route by kind, a strobe into a full bank is dropped
    assign alu_alloc = disp_valid && (disp_kind == KIND_ALU) && !alu_full;
    assign mem_alloc = disp_valid && (disp_kind == KIND_MEM) && !mem_full;

    rs_station #(.payload_t(alu_payload_t), .DEPTH(DEPTH)) alu_station (
        .clock(clock), .rst(rst), .squash(squash), .alloc(alu_alloc),
        .load_payload(disp_alu), .load_dest(disp_dest),
        .load_tag1(disp_tag1), .load_tag2(disp_tag2),
        .load_rdy1(disp_rdy1), .load_rdy2(disp_rdy2),
        .load_val1(disp_val1), .load_val2(disp_val2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .grant(alu_grant), .full(alu_full), .req(alu_req),
        .sel_dest(alu_dest), .sel_payload(alu_pl),
        .sel_op1(alu_op1), .sel_op2(alu_op2)
    );

    rs_station #(.payload_t(mem_payload_t), .DEPTH(DEPTH)) mem_station (
        .clock(clock), .rst(rst), .squash(squash), .alloc(mem_alloc),
        .load_payload(disp_mem), .load_dest(disp_dest),
        .load_tag1(disp_tag1), .load_tag2(disp_tag2),
        .load_rdy1(disp_rdy1), .load_rdy2(disp_rdy2),
        .load_val1(disp_val1), .load_val2(disp_val2),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .grant(mem_grant), .full(mem_full), .req(mem_req),
        .sel_dest(mem_dest), .sel_payload(mem_pl),
        .sel_op1(mem_op1), .sel_op2(mem_op2)
    );

    issue_merge u_merge (
        .clock(clock), .rst(rst),
        .alu_req(alu_req), .mem_req(mem_req), .issue_ready(issue_ready),
        .alu_dest(alu_dest), .mem_dest(mem_dest),
        .alu_op1(alu_op1), .alu_op2(alu_op2), .mem_op1(mem_op1), .mem_op2(mem_op2),
        .alu_pl(alu_pl), .mem_pl(mem_pl),
        .alu_grant(alu_grant), .mem_grant(mem_grant),
        .issue_valid(issue_valid), .issue_kind(issue_kind), .issue_dest(issue_dest),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
        .issue_alu(issue_alu), .issue_mem(issue_mem)
    );

endmodule

`default_nettype wire

//--- source/issue_merge.sv
`default_nettype none
`timescale 1ns/10ps

`include "rs_consts.svh"

// picks one of the two station requests per cycle onto the shared issue port
module issue_merge import rs_pkg::*; (
    input  wire logic         clock,
    input  wire logic         rst,
    input  wire logic         alu_req,
    input  wire logic         mem_req,
    input  wire logic         issue_ready,  // execution side can take an item
    input  wire tag_t         alu_dest,
    input  wire tag_t         mem_dest,
    input  wire value_t       alu_op1,
    input  wire value_t       alu_op2,
    input  wire value_t       mem_op1,
    input  wire value_t       mem_op2,
    input  wire alu_payload_t alu_pl,
    input  wire mem_payload_t mem_pl,
    output logic              alu_grant,
    output logic              mem_grant,
    output logic              issue_valid,
    output inst_kind_t        issue_kind,
    output tag_t              issue_dest,
    output value_t            issue_rs1,
    output value_t            issue_rs2,
    output alu_payload_t      issue_alu,
    output mem_payload_t      issue_mem
);

    logic prio_mem;  // 0 alu goes first on a tie
    logic pick_mem;  // mem side drives the port

    // lone request wins, tie goes to prio
    assign pick_mem = mem_req && (!alu_req || prio_mem);

    assign issue_valid = alu_req || mem_req;
    assign alu_grant   = issue_ready && alu_req && !pick_mem;
    assign mem_grant   = issue_ready && pick_mem;

    assign issue_kind = pick_mem ? KIND_MEM : KIND_ALU;
    assign issue_dest = !issue_valid ? `RS_NULL_TAG : (pick_mem ? mem_dest : alu_dest);
    assign issue_rs1  = pick_mem ? mem_op1 : alu_op1;
    assign issue_rs2  = pick_mem ? mem_op2 : alu_op2;
    assign issue_alu  = pick_mem ? '0 : alu_pl;  // only the chosen payload shows
    assign issue_mem  = pick_mem ? mem_pl : '0;

    // flip only on an accepted issue with both sides contending
    always_ff @(posedge clock) begin
        if (rst) begin
            prio_mem <= 1'b0;
        end else if (issue_ready && alu_req && mem_req) begin
            prio_mem <= !prio_mem;
        end
    end

endmodule

`default_nettype wire

//--- source/rs_station.sv
`default_nettype none
`timescale 1ns/10ps

`include "rs_consts.svh"

// bank of DEPTH entries sharing one dispatch port and one issue request
module rs_station import rs_pkg::*; #(
    parameter type payload_t = alu_payload_t,
    parameter int  DEPTH     = `RS_DEPTH
) (
    input  wire logic     clock,
    input  wire logic     rst,
    input  wire logic     squash,
    input  wire logic     alloc,         // dispatch strobe, caller checks full
    input  wire payload_t load_payload,
    input  wire tag_t     load_dest,
    input  wire tag_t     load_tag1,
    input  wire tag_t     load_tag2,
    input  wire logic     load_rdy1,
    input  wire logic     load_rdy2,
    input  wire value_t   load_val1,
    input  wire value_t   load_val2,
    input  wire logic     cdb_valid,
    input  wire tag_t     cdb_tag,
    input  wire value_t   cdb_value,
    input  wire logic     grant,         // merger took sel_* this cycle
    output logic          full,
    output logic          req,
    output tag_t          sel_dest,
    output payload_t      sel_payload,
    output value_t        sel_op1,
    output value_t        sel_op2
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0] busy_vec;
    logic [DEPTH-1:0] ready_vec;
    logic [DEPTH-1:0] load_vec;   // one hot write select
    logic [DEPTH-1:0] clear_vec;  // one hot issue clear
    tag_t             dest_arr    [DEPTH];
    payload_t         payload_arr [DEPTH];
    value_t           op1_arr     [DEPTH];
    value_t           op2_arr     [DEPTH];
    logic [IDX_W-1:0] free_idx;   // lowest free slot
    logic [IDX_W-1:0] sel_idx;    // lowest ready slot

    // scan from the top so the lowest index is the last to win
    always_comb begin
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy_vec[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    always_comb begin
        sel_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign full = &busy_vec;
    assign req  = |ready_vec;

    // oldest-first is not needed, lowest index is the policy
    assign sel_dest    = dest_arr[sel_idx];
    assign sel_payload = payload_arr[sel_idx];
    assign sel_op1     = op1_arr[sel_idx];
    assign sel_op2     = op2_arr[sel_idx];

    for (genvar g = 0; g < DEPTH; g++) begin : g_entry
        assign load_vec[g]  = alloc && (free_idx == IDX_W'(g));
        assign clear_vec[g] = grant && (sel_idx == IDX_W'(g));  // grant implies req

        rs_entry #(
            .payload_t (payload_t)
        ) u_entry (
            .clock        (clock),
            .rst          (rst),
            .squash       (squash),
            .load         (load_vec[g]),
            .clear_entry  (clear_vec[g]),
            .load_payload (load_payload),
            .load_dest    (load_dest),
            .load_tag1    (load_tag1),
            .load_tag2    (load_tag2),
            .load_rdy1    (load_rdy1),
            .load_rdy2    (load_rdy2),
            .load_val1    (load_val1),
            .load_val2    (load_val2),
            .cdb_valid    (cdb_valid),
            .cdb_tag      (cdb_tag),
            .cdb_value    (cdb_value),
            .busy         (busy_vec[g]),
            .ready        (ready_vec[g]),
            .dest         (dest_arr[g]),
            .payload      (payload_arr[g]),
            .op1          (op1_arr[g]),
            .op2          (op2_arr[g])
        );
    end

endmodule

`default_nettype wire

//--- source/rs_entry.sv
`default_nettype none
`timescale 1ns/10ps

// single reservation station slot
// waits on two source tags, wakes up from the cdb, bypasses the bus value
// on the cycle an operand completes
module rs_entry import rs_pkg::*; #(
    parameter type payload_t = alu_payload_t
) (
    input  wire logic     clock,
    input  wire logic     rst,
    input  wire logic     squash,       // flush, same effect as rst
    input  wire logic     load,         // dispatch writes this slot
    input  wire logic     clear_entry,  // slot issued this cycle
    input  wire payload_t load_payload,
    input  wire tag_t     load_dest,
    input  wire tag_t     load_tag1,
    input  wire tag_t     load_tag2,
    input  wire logic     load_rdy1,    // operand 1 already known
    input  wire logic     load_rdy2,
    input  wire value_t   load_val1,
    input  wire value_t   load_val2,
    input  wire logic     cdb_valid,
    input  wire tag_t     cdb_tag,
    input  wire value_t   cdb_value,
    output logic          busy,
    output logic          ready,        // both operands known, combinational
    output tag_t          dest,
    output payload_t      payload,
    output value_t        op1,
    output value_t        op2
);

    logic   rdy1_q;      // operand 1 filled
    logic   rdy2_q;
    tag_t   tag1_q;      // producer tags while waiting
    tag_t   tag2_q;
    value_t val1_q;
    value_t val2_q;

    logic   hit1;        // broadcast matches a waiting operand
    logic   hit2;
    logic   load_hit1;   // broadcast matches an operand being dispatched
    logic   load_hit2;
    logic   load_ok1;    // operand known at the end of the load cycle
    logic   load_ok2;

    // wakeup compare against stored tags
    assign hit1 = cdb_valid && !rdy1_q && (cdb_tag == tag1_q);
    assign hit2 = cdb_valid && !rdy2_q && (cdb_tag == tag2_q);

    // same cycle capture at dispatch, only for a not-ready source
    assign load_hit1 = cdb_valid && !load_rdy1 && (cdb_tag == load_tag1);
    assign load_hit2 = cdb_valid && !load_rdy2 && (cdb_tag == load_tag2);
    assign load_ok1  = load_rdy1 || load_hit1;
    assign load_ok2  = load_rdy2 || load_hit2;

    // an operand completed by the current broadcast counts as ready
    assign ready = busy && (rdy1_q || hit1) && (rdy2_q || hit2);

    // bus bypass for operands not yet latched
    assign op1 = rdy1_q ? val1_q : cdb_value;
    assign op2 = rdy2_q ? val2_q : cdb_value;

    // control state
    always_ff @(posedge clock) begin
        if (rst || squash) begin
            busy   <= 1'b0;
            rdy1_q <= 1'b0;
            rdy2_q <= 1'b0;
        end else if (load) begin  // load wins over clear
            busy   <= 1'b1;
            rdy1_q <= load_ok1;
            rdy2_q <= load_ok2;
        end else if (clear_entry) begin
            busy   <= 1'b0;
        end else if (busy) begin
            if (hit1) begin
                rdy1_q <= 1'b1;
            end
            if (hit2) begin
                rdy2_q <= 1'b1;
            end
        end
    end

    // payload, tags and values
    always_ff @(posedge clock) begin
        if (load) begin
            payload <= load_payload;
            dest    <= load_dest;
            tag1_q  <= load_tag1;
            tag2_q  <= load_tag2;
            val1_q  <= load_rdy1 ? load_val1 : cdb_value;  // bus value if load_hit1
            val2_q  <= load_rdy2 ? load_val2 : cdb_value;
        end else if (busy) begin
            if (hit1) begin
                val1_q <= cdb_value;  // late wakeup
            end
            if (hit2) begin
                val2_q <= cdb_value;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rs_pkg.sv
`default_nettype none

`include "rs_consts.svh"

package rs_pkg;

    // rob tag, meaning only comes from the ready bits next to it
    typedef logic [`RS_TAG_W-1:0] tag_t;

    typedef logic [`RS_XLEN-1:0] value_t;  // operand value

    // alu operation select
    typedef enum logic [`RS_FUNC_W-1:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_AND = 4'h2,
        ALU_OR  = 4'h3,
        ALU_XOR = 4'h4,
        ALU_SLL = 4'h5,
        ALU_SRL = 4'h6
    } alu_func_t;

    // which station an instruction goes to
    typedef enum logic {
        KIND_ALU = 1'b0,
        KIND_MEM = 1'b1
    } inst_kind_t;

    // alu payload, 37 bits
    typedef struct packed {
        alu_func_t func;     // operation
        value_t    imm;      // immediate, replaces op2 downstream
        logic      use_imm;  // take imm instead of rs2
    } alu_payload_t;

    // memory payload, 15 bits
    typedef struct packed {
        logic                      store;   // 1 store, 0 load
        logic [`RS_MEM_SIZE_W-1:0] size;    // byte, half, word
        logic [`RS_MEM_OFS_W-1:0]  offset;  // address offset added to rs1
    } mem_payload_t;

endpackage

`default_nettype wire

//--- source/rs_consts.svh
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// operand and immediate width
`define RS_XLEN 32

// reorder buffer tag width, 32 tags in flight
`define RS_TAG_W 5

// entries per station unless the top overrides it
`define RS_DEPTH 4

// tag shown on the issue port when nothing is offered
`define RS_NULL_TAG {`RS_TAG_W{1'b0}}

// payload field widths for the memory side
`define RS_MEM_SIZE_W 2
`define RS_MEM_OFS_W 12

// alu function code width
`define RS_FUNC_W 4

`endif
